//--- mc_settings.svh
`ifndef MC_SETTINGS_SVH
`define MC_SETTINGS_SVH

// AXI port geometry
`define MC_DATA_W       512
`define MC_ADDR_W       33
`define MC_ID_W         6
`define MC_ID_CYCLE     8     // IDs used round robin per phase

// Burst shape, one 64 byte beat per data word
`define MC_BURST_LEN    256
`define MC_BURST_BYTES  (`MC_BURST_LEN * 64)

// Pattern generator
`define MC_LFSR_W       128

// First burst of every phase starts here
`define MC_START_ADDR   0

`endif

//--- mc_pkg.sv
`default_nettype none
`include "mc_settings.svh"

package mc_pkg;

	// AW and AR carry the same payload
	typedef struct packed {
		logic [`MC_ADDR_W-1:0] addr;
		logic [`MC_ID_W-1:0]   id;
		logic [7:0]            len;
		logic [2:0]            size;
		logic [1:0]            burst;
	} axi_addr_t;

	typedef struct packed {
		logic [`MC_DATA_W-1:0] data;
		logic                  last;
	} axi_wbeat_t;

	typedef struct packed {
		logic [`MC_DATA_W-1:0] data;
		logic                  last;
		logic [`MC_ID_W-1:0]   id;
		logic [1:0]            resp;
	} axi_rbeat_t;

	typedef enum logic [1:0] {
		MC_WRITE_READ = 2'd0,
		MC_WRITE_ONLY = 2'd1,
		MC_READ_ONLY  = 2'd2
	} mc_mode_e;

	typedef struct packed {
		logic [`MC_LFSR_W-1:0] seed;
		logic [31:0]           check_mask;  // Repeated over every 32-bit lane
		logic                  lfsr_en;
		logic [31:0]           test_size;
		mc_mode_e              mode;
	} mc_cfg_t;

	typedef struct packed {
		logic        done;
		logic        fail;
		logic [31:0] dq_fail;   // One bit per DQ line
	} mc_status_t;

	// Full length INCR burst of full width beats
	function automatic axi_addr_t mc_burst(input logic [`MC_ADDR_W-1:0] addr,
			input logic [`MC_ID_W-1:0] id);
		axi_addr_t a;
		a.addr  = addr;
		a.id    = id;
		a.len   = 8'(`MC_BURST_LEN - 1);
		a.size  = 3'($clog2(`MC_DATA_W / 8));
		a.burst = 2'b01;
		return a;
	endfunction

endpackage

`default_nettype wire

//--- pattern_lfsr.sv
`timescale 1ns/1ps
`default_nettype none
`include "mc_settings.svh"

module pattern_lfsr (
	input  logic                  axi_clk,
	input  logic                  rstn,
	input  logic                  i_load,
	input  logic [`MC_LFSR_W-1:0] i_seed,
	input  logic                  i_advance,
	input  logic                  i_enable,
	input  logic [31:0]           i_mask,
	output logic [`MC_DATA_W-1:0] o_word
);
	localparam int REPS  = `MC_DATA_W / `MC_LFSR_W;
	localparam int LANES = `MC_DATA_W / 32;

	logic [`MC_LFSR_W-1:0] lfsr_q;
	logic                  fb;

	// Maximal length taps for 128 bits, XNOR form
	assign fb = ~(lfsr_q[98] ^ lfsr_q[100] ^ lfsr_q[125] ^ lfsr_q[127]);

	always_ff @(posedge axi_clk or negedge rstn) begin
		if (!rstn) begin
			lfsr_q <= '0;
		end else if (i_load) begin
			lfsr_q <= i_seed;
		end else if (i_advance && i_enable) begin
			lfsr_q <= {lfsr_q[`MC_LFSR_W-2:0], fb};
		end
	end

	// With the LFSR off the state never leaves the seed
	assign o_word = {REPS{lfsr_q}} & {LANES{i_mask}};

endmodule

`default_nettype wire

//--- axi_write_engine.sv
`timescale 1ns/1ps
`default_nettype none
`include "mc_settings.svh"

module axi_write_engine
	import mc_pkg::*;
(
	input  logic                 axi_clk,
	input  logic                 rstn,
	input  logic                 i_cmd,
	input  logic [`MC_ADDR_W-1:0] i_addr,
	input  logic [`MC_ID_W-1:0]  i_id,
	input  mc_cfg_t              i_cfg,
	input  logic                 i_pat_load,
	output axi_addr_t            o_aw,
	output logic                 o_awvalid,
	input  logic                 i_awready,
	output axi_wbeat_t           o_w,
	output logic                 o_wvalid,
	input  logic                 i_wready,
	input  logic                 i_bvalid,
	output logic                 o_bready,
	output logic                 o_burst_done
);
	localparam int CNT_W = $clog2(`MC_BURST_LEN);

	logic [CNT_W-1:0]      beat_cnt;
	logic [`MC_DATA_W-1:0] pat_word;
	logic                  w_fire;
	logic                  last_beat;

	assign w_fire    = o_wvalid & i_wready;
	assign last_beat = (beat_cnt == CNT_W'(`MC_BURST_LEN - 1));

	// Pattern only moves on an accepted beat, so wdata is stable while stalled
	pattern_lfsr u_pat (
		.axi_clk   (axi_clk),
		.rstn      (rstn),
		.i_load    (i_pat_load),
		.i_seed    (i_cfg.seed),
		.i_advance (w_fire),
		.i_enable  (i_cfg.lfsr_en),
		.i_mask    (i_cfg.check_mask),
		.o_word    (pat_word)
	);

	assign o_w.data = pat_word;
	assign o_w.last = last_beat;

	always_ff @(posedge axi_clk) begin
		if (i_cmd) begin
			o_aw <= mc_burst(i_addr, i_id);
		end
	end

	always_ff @(posedge axi_clk or negedge rstn) begin
		if (!rstn) begin
			o_awvalid    <= 1'b0;
			o_wvalid     <= 1'b0;
			o_bready     <= 1'b0;
			o_burst_done <= 1'b0;
			beat_cnt     <= '0;
		end else begin
			o_burst_done <= o_bready & i_bvalid;    // One cycle after B
			if (i_cmd) begin
				o_awvalid <= 1'b1;
				o_wvalid  <= 1'b1;
				beat_cnt  <= '0;
			end else begin
				if (o_awvalid && i_awready) begin
					o_awvalid <= 1'b0;
				end
				if (w_fire) begin
					beat_cnt <= beat_cnt + 1'b1;
					// Data phase over, wait for the response
					if (last_beat) begin
						o_wvalid <= 1'b0;
						o_bready <= 1'b1;
					end
				end
				if (o_bready && i_bvalid) begin
					o_bready <= 1'b0;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- axi_read_checker.sv
`timescale 1ns/1ps
`default_nettype none
`include "mc_settings.svh"

module axi_read_checker
	import mc_pkg::*;
(
	input  logic                 axi_clk,
	input  logic                 rstn,
	input  logic                 i_cmd,
	input  logic [`MC_ADDR_W-1:0] i_addr,
	input  logic [`MC_ID_W-1:0]  i_id,
	input  mc_cfg_t              i_cfg,
	input  logic                 i_pat_load,
	output axi_addr_t            o_ar,
	output logic                 o_arvalid,
	input  logic                 i_arready,
	input  axi_rbeat_t           i_r,
	input  logic                 i_rvalid,
	output logic                 o_rready,
	output logic                 o_burst_done,
	output logic                 o_fail,
	output logic [31:0]          o_dq_fail
);
	localparam int LANES = `MC_DATA_W / 32;

	logic [`MC_DATA_W-1:0] exp_word;
	logic [`MC_DATA_W-1:0] mask_word;
	logic [`MC_DATA_W-1:0] diff;
	logic [`MC_DATA_W-1:0] r_data_q;   // Input pipeline stage
	logic                  r_last_q;
	logic                  r_valid_q;
	logic                  r_fire;
	logic [31:0]           lane_or;

	assign r_fire    = i_rvalid & o_rready;
	assign mask_word = {LANES{i_cfg.check_mask}};
	assign diff      = (r_data_q & mask_word) ^ exp_word;

	// Expected word steps with each compared beat
	pattern_lfsr u_pat (
		.axi_clk   (axi_clk),
		.rstn      (rstn),
		.i_load    (i_pat_load),
		.i_seed    (i_cfg.seed),
		.i_advance (r_valid_q),
		.i_enable  (i_cfg.lfsr_en),
		.i_mask    (i_cfg.check_mask),
		.o_word    (exp_word)
	);

	// Fold the 16 lanes onto the 32 DQ lines
	always_comb begin
		lane_or = '0;
		for (int i = 0; i < LANES; i++) begin
			lane_or = lane_or | diff[i*32 +: 32];
		end
	end

	always_ff @(posedge axi_clk) begin
		if (i_cmd) begin
			o_ar <= mc_burst(i_addr, i_id);
		end
		if (r_fire) begin
			r_data_q <= i_r.data;
			r_last_q <= i_r.last;
		end
	end

	always_ff @(posedge axi_clk or negedge rstn) begin
		if (!rstn) begin
			o_arvalid    <= 1'b0;
			o_rready     <= 1'b0;
			r_valid_q    <= 1'b0;
			o_burst_done <= 1'b0;
			o_fail       <= 1'b0;
			o_dq_fail    <= '0;
		end else begin
			r_valid_q    <= r_fire;
			o_burst_done <= r_valid_q & r_last_q;
			if (i_cmd) begin
				o_arvalid <= 1'b1;
			end else if (o_arvalid && i_arready) begin
				o_arvalid <= 1'b0;
				o_rready  <= 1'b1;
			end
			if (r_fire && i_r.last) begin
				o_rready <= 1'b0;
			end
			// Sticky results, cleared at the start of a run
			if (i_pat_load) begin
				o_fail    <= 1'b0;
				o_dq_fail <= '0;
			end else if (r_valid_q) begin
				if (|diff) begin
					o_fail <= 1'b1;
				end
				o_dq_fail <= o_dq_fail | lane_or;
			end
		end
	end

endmodule

`default_nettype wire

//--- mem_test_ctrl.sv
`timescale 1ns/1ps
`default_nettype none
`include "mc_settings.svh"

module mem_test_ctrl
	import mc_pkg::*;
(
	input  logic                  axi_clk,
	input  logic                  rstn,
	input  logic                  i_start,
	input  mc_cfg_t               i_cfg,
	output logic                  o_pat_load,
	output logic                  o_wr_cmd,
	output logic                  o_rd_cmd,
	output logic [`MC_ADDR_W-1:0] o_addr,
	output logic [`MC_ID_W-1:0]   o_id,
	input  logic                  i_wr_burst_done,
	input  logic                  i_rd_burst_done,
	output logic                  o_done
);
	localparam int AW    = `MC_ADDR_W;
	localparam int ID_CW = $clog2(`MC_ID_CYCLE);
	localparam logic [AW-1:0] START_ADDR  = AW'(`MC_START_ADDR);
	localparam logic [AW-1:0] BURST_BYTES = AW'(`MC_BURST_BYTES);

	typedef enum logic [1:0] {ST_IDLE, ST_WRITE, ST_READ, ST_DONE} state_e;

	state_e            state;
	logic [1:0]        start_sync;
	logic [ID_CW-1:0]  id_cnt;
	logic              last_burst;

	assign last_burst = (o_addr >= AW'(i_cfg.test_size));  // Region end reached
	assign o_id       = {{(`MC_ID_W - ID_CW){1'b0}}, id_cnt};

	always_ff @(posedge axi_clk or negedge rstn) begin
		if (!rstn) begin
			start_sync <= 2'b00;
		end else begin
			start_sync <= {start_sync[0], i_start};
		end
	end

	always_ff @(posedge axi_clk or negedge rstn) begin
		if (!rstn) begin
			state      <= ST_IDLE;
			o_pat_load <= 1'b0;
			o_wr_cmd   <= 1'b0;
			o_rd_cmd   <= 1'b0;
			o_addr     <= START_ADDR;
			id_cnt     <= '0;
			o_done     <= 1'b0;
		end else begin
			o_pat_load <= 1'b0;
			o_wr_cmd   <= 1'b0;
			o_rd_cmd   <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (start_sync[1]) begin
						o_pat_load <= 1'b1;
						o_addr     <= START_ADDR;
						id_cnt     <= '0;
						if (i_cfg.mode == MC_READ_ONLY) begin
							state    <= ST_READ;
							o_rd_cmd <= 1'b1;
						end else begin
							state    <= ST_WRITE;
							o_wr_cmd <= 1'b1;
						end
					end
				end
				ST_WRITE: if (i_wr_burst_done) begin
					if (!last_burst) begin
						o_addr   <= o_addr + BURST_BYTES;
						id_cnt   <= id_cnt + 1'b1;
						o_wr_cmd <= 1'b1;
					end else if (i_cfg.mode == MC_WRITE_ONLY) begin
						state  <= ST_DONE;
						o_done <= 1'b1;
					end else begin
						// Read back from the top, IDs restart
						state    <= ST_READ;
						o_addr   <= START_ADDR;
						id_cnt   <= '0;
						o_rd_cmd <= 1'b1;
					end
				end
				ST_READ: if (i_rd_burst_done) begin
					if (last_burst) begin
						state  <= ST_DONE;
						o_done <= 1'b1;
					end else begin
						o_addr   <= o_addr + BURST_BYTES;
						id_cnt   <= id_cnt + 1'b1;
						o_rd_cmd <= 1'b1;
					end
				end
				ST_DONE: begin
					if (!start_sync[1]) begin
						state  <= ST_IDLE;
						o_done <= 1'b0;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- memory_checker_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "mc_settings.svh"

module memory_checker_top
	import mc_pkg::*;
(
	input  logic       axi_clk,
	input  logic       rstn,
	input  logic       i_start,
	input  mc_cfg_t    i_cfg,
	output mc_status_t o_status,
	output axi_addr_t  o_aw,
	output logic       o_awvalid,
	input  logic       i_awready,
	output axi_wbeat_t o_w,
	output logic       o_wvalid,
	input  logic       i_wready,
	input  logic       i_bvalid,
	output logic       o_bready,
	output axi_addr_t  o_ar,
	output logic       o_arvalid,
	input  logic       i_arready,
	input  axi_rbeat_t i_r,
	input  logic       i_rvalid,
	output logic       o_rready
);
	logic                  pat_load;
	logic                  wr_cmd;
	logic                  rd_cmd;
	logic [`MC_ADDR_W-1:0] cmd_addr;
	logic [`MC_ID_W-1:0]   cmd_id;
	logic                  wr_burst_done;
	logic                  rd_burst_done;
	logic                  done;
	logic                  fail;
	logic [31:0]           dq_fail;

	mem_test_ctrl u_ctrl (
		.axi_clk         (axi_clk),
		.rstn            (rstn),
		.i_start         (i_start),
		.i_cfg           (i_cfg),
		.o_pat_load      (pat_load),
		.o_wr_cmd        (wr_cmd),
		.o_rd_cmd        (rd_cmd),
		.o_addr          (cmd_addr),
		.o_id            (cmd_id),
		.i_wr_burst_done (wr_burst_done),
		.i_rd_burst_done (rd_burst_done),
		.o_done          (done)
	);

	axi_write_engine u_wr (
		.axi_clk      (axi_clk),
		.rstn         (rstn),
		.i_cmd        (wr_cmd),
		.i_addr       (cmd_addr),
		.i_id         (cmd_id),
		.i_cfg        (i_cfg),
		.i_pat_load   (pat_load),
		.o_aw         (o_aw),
		.o_awvalid    (o_awvalid),
		.i_awready    (i_awready),
		.o_w          (o_w),
		.o_wvalid     (o_wvalid),
		.i_wready     (i_wready),
		.i_bvalid     (i_bvalid),
		.o_bready     (o_bready),
		.o_burst_done (wr_burst_done)
	);

	axi_read_checker u_rd (
		.axi_clk      (axi_clk),
		.rstn         (rstn),
		.i_cmd        (rd_cmd),
		.i_addr       (cmd_addr),
		.i_id         (cmd_id),
		.i_cfg        (i_cfg),
		.i_pat_load   (pat_load),
		.o_ar         (o_ar),
		.o_arvalid    (o_arvalid),
		.i_arready    (i_arready),
		.i_r          (i_r),
		.i_rvalid     (i_rvalid),
		.o_rready     (o_rready),
		.o_burst_done (rd_burst_done),
		.o_fail       (fail),
		.o_dq_fail    (dq_fail)
	);

	assign o_status.done    = done;
	assign o_status.fail    = fail;
	assign o_status.dq_fail = dq_fail;

endmodule

`default_nettype wire

//--- tb_checker_monitor.sv
`timescale 1ns/1ps
`default_nettype none
`include "mc_settings.svh"

module tb_checker_monitor
	import mc_pkg::*;
(
	input logic       axi_clk,
	input logic       rstn,
	input mc_cfg_t    i_cfg,
	input mc_status_t i_status,
	input axi_addr_t  i_aw,
	input logic       i_awvalid,
	input logic       i_awready,
	input axi_wbeat_t i_w,
	input logic       i_wvalid,
	input logic       i_wready,
	input logic       i_bready,
	input axi_addr_t  i_ar,
	input logic       i_arvalid,
	input logic       i_arready,
	input logic       i_rready
);
	int                    errors = 0;
	string                 test_name = "";
	int                    aw_cnt;
	int                    ar_cnt;
	int                    w_cnt;
	logic [`MC_LFSR_W-1:0] w_state;       // Predicted LFSR state for the next W beat
	axi_addr_t             aw_hold;
	axi_addr_t             ar_hold;
	axi_wbeat_t            w_hold;
	logic                  aw_wait = 1'b0;
	logic                  ar_wait = 1'b0;
	logic                  w_wait  = 1'b0;
	logic                  after_reset = 1'b0;   // Next edge is the first out of reset

	// Shift up one place, XNOR of taps 98, 100, 125, 127 into bit 0
	function automatic logic [`MC_LFSR_W-1:0] lfsr_next(input logic [`MC_LFSR_W-1:0] s);
		return {s[`MC_LFSR_W-2:0], ~(s[98] ^ s[100] ^ s[125] ^ s[127])};
	endfunction

	function automatic logic [`MC_DATA_W-1:0] masked_word(input logic [`MC_LFSR_W-1:0] s,
			input logic [31:0] m);
		return {4{s}} & {16{m}};
	endfunction

	// Burst n of a phase: fixed INCR shape, 64 byte beats
	function automatic axi_addr_t burst_expect(input int n);
		axi_addr_t a;
		a.addr  = `MC_ADDR_W'(`MC_START_ADDR + n * `MC_BURST_BYTES);
		a.id    = `MC_ID_W'(n % `MC_ID_CYCLE);
		a.len   = 8'd255;
		a.size  = 3'd6;
		a.burst = 2'b01;
		return a;
	endfunction

	task automatic report_value(input string what, input logic [520:0] exp_v,
			input logic [520:0] act_v);
		errors++;
		$display("[ERROR] %s %s: expected %0h actual %0h", test_name, what, exp_v, act_v);
	endtask

	task automatic check_hold(input string chan, input logic waiting, input logic valid,
			input logic [520:0] held, input logic [520:0] now);
		if (waiting && !valid) begin
			errors++;
			$display("%s: %s valid dropped before its transfer", test_name, chan);
		end else if (waiting && held !== now) begin
			report_value({chan, " payload while stalled"}, held, now);
		end
	endtask

	task automatic begin_test(input string name, input logic [`MC_LFSR_W-1:0] seed);
		test_name = name;
		aw_cnt    = 0;
		ar_cnt    = 0;
		w_cnt     = 0;
		w_state   = seed;
	endtask

	task automatic check_end(input int wr_bursts, input int rd_bursts, input logic exp_fail,
			input logic [31:0] exp_dq);
		if (aw_cnt != wr_bursts) report_value("AW burst count", wr_bursts, aw_cnt);
		if (w_cnt != wr_bursts * `MC_BURST_LEN) begin
			report_value("W beat count", wr_bursts * `MC_BURST_LEN, w_cnt);
		end
		if (ar_cnt != rd_bursts) report_value("AR burst count", rd_bursts, ar_cnt);
		if (i_status.fail !== exp_fail) report_value("fail flag", exp_fail, i_status.fail);
		if (i_status.dq_fail !== exp_dq) report_value("dq_fail map", exp_dq, i_status.dq_fail);
		// All bursts are complete, so every channel is idle
		if ({i_awvalid, i_wvalid, i_bready, i_arvalid, i_rready} !== 5'd0) begin
			report_value("valid and ready outputs at done", 5'd0,
				{i_awvalid, i_wvalid, i_bready, i_arvalid, i_rready});
		end
	endtask

	always @(posedge axi_clk) begin : watch
		axi_addr_t  exp_a;
		axi_wbeat_t exp_w;
		if (!rstn) begin
			aw_wait     = 1'b0;
			ar_wait     = 1'b0;
			w_wait      = 1'b0;
			after_reset = 1'b1;
		end else begin
			if (after_reset) begin
				if ({i_awvalid, i_wvalid, i_bready, i_arvalid, i_rready, i_status.done,
						i_status.fail} !== 7'd0) begin
					errors++;
					$display("A valid, ready, done or fail output is not low after reset");
				end
				after_reset = 1'b0;
			end
			check_hold("AW", aw_wait, i_awvalid, aw_hold, i_aw);
			check_hold("W", w_wait, i_wvalid, w_hold, i_w);
			check_hold("AR", ar_wait, i_arvalid, ar_hold, i_ar);
			if (i_awvalid && i_awready) begin
				exp_a = burst_expect(aw_cnt);
				if (i_aw !== exp_a) report_value("AW burst", exp_a, i_aw);
				aw_cnt++;
			end
			if (i_arvalid && i_arready) begin
				exp_a = burst_expect(ar_cnt);    // IDs and addresses restart per phase
				if (i_ar !== exp_a) report_value("AR burst", exp_a, i_ar);
				ar_cnt++;
			end
			if (i_wvalid && i_wready) begin
				exp_w.data = masked_word(w_state, i_cfg.check_mask);
				exp_w.last = (w_cnt % `MC_BURST_LEN) == `MC_BURST_LEN - 1;
				if (i_w !== exp_w) report_value("W beat", exp_w, i_w);
				w_cnt++;
				if (i_cfg.lfsr_en) w_state = lfsr_next(w_state);
			end
			aw_wait = i_awvalid && !i_awready;
			ar_wait = i_arvalid && !i_arready;
			w_wait  = i_wvalid && !i_wready;
			aw_hold = i_aw;
			ar_hold = i_ar;
			w_hold  = i_w;
		end
	end

endmodule

`default_nettype wire

//--- tb_memory_checker.sv
`timescale 1ns/1ps
`default_nettype none
`include "mc_settings.svh"

module tb_memory_checker
	import mc_pkg::*;
();
	localparam int RUN_LIMIT = 200000;    // Cycles allowed for one run

	logic       axi_clk;
	logic       rstn;
	logic       start;
	mc_cfg_t    cfg;
	mc_status_t status;
	axi_addr_t  aw;
	logic       awvalid;
	logic       awready;
	axi_wbeat_t w;
	logic       wvalid;
	logic       wready;
	logic       bvalid;
	logic       bready;
	axi_addr_t  ar;
	logic       arvalid;
	logic       arready;
	axi_rbeat_t r;
	logic       rvalid;
	logic       rready;

	// Memory model state
	logic [`MC_DATA_W-1:0] mem [logic [`MC_ADDR_W-1:0]];
	logic [`MC_ADDR_W-1:0] aw_q [$];
	logic [`MC_DATA_W-1:0] w_buf [$];
	int                    w_bursts;
	logic [`MC_ADDR_W-1:0] rd_base;
	logic [`MC_ID_W-1:0]   rd_id;
	int                    rd_beat;
	logic                  rd_busy;
	int                    run_beat;     // Read beats since the run started
	logic                  inj_en;
	int                    inj_beat;
	int                    inj_bit;
	int                    stall_pct;
	int                    tests;

	memory_checker_top uut (
		.axi_clk   (axi_clk),
		.rstn      (rstn),
		.i_start   (start),
		.i_cfg     (cfg),
		.o_status  (status),
		.o_aw      (aw),
		.o_awvalid (awvalid),
		.i_awready (awready),
		.o_w       (w),
		.o_wvalid  (wvalid),
		.i_wready  (wready),
		.i_bvalid  (bvalid),
		.o_bready  (bready),
		.o_ar      (ar),
		.o_arvalid (arvalid),
		.i_arready (arready),
		.i_r       (r),
		.i_rvalid  (rvalid),
		.o_rready  (rready)
	);

	tb_checker_monitor mon (
		.axi_clk   (axi_clk),
		.rstn      (rstn),
		.i_cfg     (cfg),
		.i_status  (status),
		.i_aw      (aw),
		.i_awvalid (awvalid),
		.i_awready (awready),
		.i_w       (w),
		.i_wvalid  (wvalid),
		.i_wready  (wready),
		.i_bready  (bready),
		.i_ar      (ar),
		.i_arvalid (arvalid),
		.i_arready (arready),
		.i_rready  (rready)
	);

	always #4 axi_clk = ~axi_clk;

	function automatic logic ready_roll();
		return ($urandom % 100) >= stall_pct;
	endfunction

	// AW and W collect a burst, B commits it to memory
	always @(posedge axi_clk) begin : write_side
		logic [`MC_ADDR_W-1:0] base;
		if (rstn) begin
			awready <= ready_roll();
			wready  <= ready_roll();
			if (awvalid && awready) aw_q.push_back(aw.addr);
			if (wvalid && wready) begin
				w_buf.push_back(w.data);
				if (w.last) w_bursts++;
			end
			if (bvalid && bready) begin
				bvalid <= 1'b0;
				base = aw_q.pop_front();
				for (int k = 0; k < `MC_BURST_LEN; k++) begin
					mem[base + k * 64] = w_buf.pop_front();
				end
				w_bursts--;
			end else if (!bvalid && w_bursts > 0 && aw_q.size() > 0) begin
				bvalid <= ready_roll();
			end
		end
	end

	always @(posedge axi_clk) begin : read_side
		logic [`MC_ADDR_W-1:0] a;
		axi_rbeat_t            beat;
		if (rstn) begin
			arready <= ready_roll();
			if (arvalid && arready) begin
				rd_base = ar.addr;
				rd_id   = ar.id;
				rd_beat = 0;
				rd_busy = 1'b1;
			end
			if (rvalid && rready) begin
				rd_beat++;
				run_beat++;
				if (rd_beat == `MC_BURST_LEN) rd_busy = 1'b0;
			end
			if (!rvalid || rready) begin    // A waiting beat stays as it is
				if (rd_busy && ready_roll()) begin
					a = rd_base + rd_beat * 64;
					beat.data = mem.exists(a) ? mem[a] : '0;
					if (inj_en && run_beat == inj_beat) beat.data[inj_bit] = ~beat.data[inj_bit];
					beat.last = (rd_beat == `MC_BURST_LEN - 1);
					beat.id   = rd_id;
					beat.resp = 2'b00;
					r      <= beat;
					rvalid <= 1'b1;
				end else begin
					rvalid <= 1'b0;
				end
			end
		end
	end

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("SOME TESTS FAILED");
		$finish;
	endtask

	// inj_kind 0 is clean, 1 flips a checked bit, 2 flips a bit outside the mask
	task automatic run_test(input string name, input mc_mode_e mode, input logic lfsr_on,
			input int inj_kind, input int stall);
		mc_cfg_t               c;
		logic [`MC_LFSR_W-1:0] s;
		int                    bursts;
		int                    bit_sel;
		int                    t;
		c.seed       = {$urandom, $urandom, $urandom, $urandom};
		c.check_mask = $urandom;
		c.lfsr_en    = lfsr_on;
		c.test_size  = $urandom % (3 * `MC_BURST_BYTES);
		c.mode       = mode;
		bit_sel      = $urandom % `MC_DATA_W;
		if (inj_kind == 1) c.check_mask[bit_sel % 32] = 1'b1;
		if (inj_kind == 2) c.check_mask[bit_sel % 32] = 1'b0;
		bursts = (c.test_size + `MC_BURST_BYTES - 1) / `MC_BURST_BYTES + 1;
		if (mode == MC_READ_ONLY) begin
			mem.delete();
			s = c.seed;
			for (int k = 0; k < bursts * `MC_BURST_LEN; k++) begin
				mem[`MC_START_ADDR + k * 64] = mon.masked_word(s, c.check_mask);
				if (c.lfsr_en) s = mon.lfsr_next(s);
			end
		end
		inj_en    = (inj_kind != 0);
		inj_beat  = $urandom % (bursts * `MC_BURST_LEN);
		inj_bit   = bit_sel;
		run_beat  = 0;
		stall_pct = stall;
		cfg <= c;
		@(posedge axi_clk);
		mon.begin_test(name, c.seed);
		start <= 1'b1;
		t = 0;
		while (!status.done && t < RUN_LIMIT) begin
			@(posedge axi_clk);
			t++;
		end
		if (!status.done) abort_run({name, ": done did not rise before the timeout"});
		mon.check_end(mode == MC_READ_ONLY ? 0 : bursts, mode == MC_WRITE_ONLY ? 0 : bursts,
			inj_kind == 1 && mode != MC_WRITE_ONLY,
			(inj_kind == 1) ? (32'd1 << (bit_sel % 32)) : 32'd0);
		start <= 1'b0;
		t = 0;
		while (status.done && t < 20) begin
			@(posedge axi_clk);
			t++;
		end
		if (status.done) abort_run({name, ": done stayed high after start was released"});
		inj_en = 1'b0;
		tests++;
	endtask

	initial begin
		axi_clk   = 1'b0;
		rstn      = 1'b0;
		start     = 1'b0;
		cfg       = '0;
		awready   = 1'b0;
		wready    = 1'b0;
		bvalid    = 1'b0;
		arready   = 1'b0;
		r         = '0;
		rvalid    = 1'b0;
		w_bursts  = 0;
		rd_busy   = 1'b0;
		rd_beat   = 0;
		run_beat  = 0;
		inj_en    = 1'b0;
		inj_beat  = 0;
		inj_bit   = 0;
		stall_pct = 30;
		tests     = 0;
		void'($urandom(30));
		repeat (10) @(posedge axi_clk);
		rstn <= 1'b1;
		repeat (2) @(posedge axi_clk);
		run_test("write_read_lfsr", MC_WRITE_READ, 1'b1, 0, 30);
		run_test("write_read_fixed", MC_WRITE_READ, 1'b0, 0, 30);
		run_test("flip_in_mask", MC_WRITE_READ, 1'b1, 1, 30);
		run_test("flip_out_of_mask", MC_WRITE_READ, 1'b1, 2, 30);
		run_test("write_only", MC_WRITE_ONLY, 1'b1, 0, 30);
		run_test("read_only_lfsr", MC_READ_ONLY, 1'b1, 0, 30);
		run_test("read_only_fixed", MC_READ_ONLY, 1'b0, 0, 30);
		run_test("stall_clean", MC_WRITE_READ, 1'b1, 0, 80);    // Heavy back-pressure
		run_test("stall_flip", MC_WRITE_READ, 1'b1, 1, 80);
		$display("Tests run: %0d, errors: %0d", tests, mon.errors);
		if (mon.errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- list.f
+incdir+.
mc_pkg.sv
pattern_lfsr.sv
axi_write_engine.sv
axi_read_checker.sv
mem_test_ctrl.sv
memory_checker_top.sv
tb_checker_monitor.sv
tb_memory_checker.sv

//--- Bender.yml
package:
  name: memory_checker

export_include_dirs:
  - .

sources:
  - mc_pkg.sv
  - pattern_lfsr.sv
  - axi_write_engine.sv
  - axi_read_checker.sv
  - mem_test_ctrl.sv
  - memory_checker_top.sv
  - target: test
    files:
      - tb_checker_monitor.sv
      - tb_memory_checker.sv
